// ==== verilog/exu_pkg.sv ====
package exu_pkg;

    // data path width
    parameter int xlen = 32;

    // alu operation codes, unlisted codes give zero
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,   // signed compare
        alu_sltu = 4'd4,   // unsigned compare
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_eq   = 4'd10   // equality, used by beq/bne
    } alu_op_t;

    // immediate forms
    typedef enum logic [1:0] {
        imm_12i = 2'd0,    // i/s/b style, sign extended
        imm_20u = 2'd1,    // lui/auipc upper immediate
        imm_20j = 2'd2,    // jal offset, shifted by one
        imm_5u  = 2'd3     // csr zimm
    } imm_kind_t;

    // first alu operand source
    typedef enum logic [1:0] {
        src1_rs1  = 2'd0,
        src1_pc   = 2'd1,
        src1_zero = 2'd2
    } src1_sel_t;

    // second alu operand source
    typedef enum logic [1:0] {
        src2_imm  = 2'd0,
        src2_rs2  = 2'd1,
        src2_csr  = 2'd2,
        src2_zero = 2'd3
    } src2_sel_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic [exu_pkg::xlen-1:0] operand_a,
    input  logic [exu_pkg::xlen-1:0] operand_b,
    input  exu_pkg::alu_op_t         op,
    output logic [exu_pkg::xlen-1:0] result
);

    import exu_pkg::*;

    localparam int shamt_w = $clog2(xlen);

    logic [xlen-1:0]    sum;
    logic [xlen-1:0]    diff;
    logic [shamt_w-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;

    assign sum   = operand_a + operand_b;
    assign diff  = operand_a - operand_b;
    assign shamt = operand_b[shamt_w-1:0]; // only the low bits count

    assign lt_signed   = $signed(operand_a) < $signed(operand_b);
    assign lt_unsigned = operand_a < operand_b;
    assign equal       = operand_a == operand_b;

    always_comb begin
        case (op)
            alu_add: begin
                result = sum;
            end
            alu_sub: begin
                result = diff;
            end
            alu_sll: begin
                result = operand_a << shamt;
            end
            alu_slt: begin
                result = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                result = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                result = operand_a ^ operand_b;
            end
            alu_srl: begin
                result = operand_a >> shamt;
            end
            alu_sra: begin
                result = $unsigned($signed(operand_a) >>> shamt); // keeps sign bit
            end
            alu_or: begin
                result = operand_a | operand_b;
            end
            alu_and: begin
                result = operand_a & operand_b;
            end
            alu_eq: begin
                result = {{(xlen-1){1'b0}}, equal};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// ==== verilog/imm_expand.sv ====
`timescale 1ns/1ps

module imm_expand (
    input  logic [exu_pkg::xlen-1:0] imm_raw,
    input  exu_pkg::imm_kind_t       kind,
    output logic [exu_pkg::xlen-1:0] imm_value
);

    import exu_pkg::*;

    logic [xlen-1:0] ext_12i;
    logic [xlen-1:0] ext_20u;
    logic [xlen-1:0] ext_20j;
    logic [xlen-1:0] ext_5u;

    assign ext_12i = {{(xlen-12){imm_raw[11]}}, imm_raw[11:0]};
    assign ext_20u = {imm_raw[19:0], {(xlen-20){1'b0}}};      // lower bits cleared
    assign ext_20j = {{(xlen-21){imm_raw[19]}}, imm_raw[19:0], 1'b0};
    assign ext_5u  = {{(xlen-5){1'b0}}, imm_raw[4:0]};

    // jump offsets are always even, hence the extra zero bit

    always_comb begin
        case (kind)
            imm_12i: begin
                imm_value = ext_12i;
            end
            imm_20u: begin
                imm_value = ext_20u;
            end
            imm_20j: begin
                imm_value = ext_20j;
            end
            imm_5u: begin
                imm_value = ext_5u;
            end
            default: begin
                imm_value = '0;
            end
        endcase
    end

endmodule

// ==== verilog/exu.sv ====
`timescale 1ns/1ps

module exu #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    // handshake
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      out_valid,
    input  logic                      out_ready,
    // instruction fields from decode
    input  logic [exu_pkg::xlen-1:0]  pc,
    input  logic [31:0]               inst,
    input  logic [4:0]                rd,
    input  logic [2:0]                funct3,
    input  logic                      reg_wen,
    input  logic                      mem_wen,
    input  logic                      mem_ren,
    input  logic [3:0]                csr_wen,
    input  logic [exu_pkg::xlen-1:0]  imm,
    input  exu_pkg::imm_kind_t        imm_kind,
    input  exu_pkg::alu_op_t          alu_op,
    input  exu_pkg::src1_sel_t        src1_sel,
    input  exu_pkg::src2_sel_t        src2_sel,
    input  logic                      invert,
    input  logic                      jump,
    input  logic                      branch,
    input  logic                      fetch_i,
    input  logic [exu_pkg::xlen-1:0]  rs1_value,
    input  logic [exu_pkg::xlen-1:0]  rs2_value,
    input  logic [exu_pkg::xlen-1:0]  csr_value,
    // fields toward memory / write-back
    output logic [exu_pkg::xlen-1:0]  pc_out,
    output logic [31:0]               inst_out,
    output logic [4:0]                rd_out,
    output logic [2:0]                funct3_out,
    output logic                      reg_wen_out,
    output logic                      mem_wen_out,
    output logic                      mem_ren_out,
    output logic [3:0]                csr_wen_out,
    output logic                      jump_out,
    output logic                      branch_out,
    output logic                      fetch_i_out,
    output logic [exu_pkg::xlen-1:0]  imm_out,
    output logic [exu_pkg::xlen-1:0]  rs2_value_out,
    output logic [exu_pkg::xlen-1:0]  csr_value_out,
    output logic [exu_pkg::xlen-1:0]  result,
    output logic [COUNT_WIDTH-1:0]    exec_count
);

    import exu_pkg::*;

    logic            accept;
    logic [xlen-1:0] rs1_q;
    imm_kind_t       imm_kind_q;
    alu_op_t         alu_op_q;
    src1_sel_t       src1_sel_q;
    src2_sel_t       src2_sel_q;
    logic            invert_q;
    logic [xlen-1:0] imm_value;
    logic [xlen-1:0] operand_a;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_result;

    // one-entry stage, free when empty or draining this cycle
    assign in_ready = out_ready | ~out_valid;
    assign accept   = in_valid & in_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid  <= 1'b0;
            exec_count <= '0;
        end else begin
            if (in_ready) begin
                out_valid <= in_valid; // held while downstream stalls
            end
            if (accept) begin
                exec_count <= exec_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pc_out        <= '0;
            inst_out      <= '0;
            rd_out        <= '0;
            funct3_out    <= '0;
            reg_wen_out   <= 1'b0;
            mem_wen_out   <= 1'b0;
            mem_ren_out   <= 1'b0;
            csr_wen_out   <= '0;
            jump_out      <= 1'b0;
            branch_out    <= 1'b0;
            fetch_i_out   <= 1'b0;
            imm_out       <= '0;
            rs2_value_out <= '0;
            csr_value_out <= '0;
            rs1_q         <= '0;
            imm_kind_q    <= imm_12i;
            alu_op_q      <= alu_add;
            src1_sel_q    <= src1_rs1;
            src2_sel_q    <= src2_imm;
            invert_q      <= 1'b0;
        end else if (accept) begin
            pc_out        <= pc;
            inst_out      <= inst;
            rd_out        <= rd;
            funct3_out    <= funct3;
            reg_wen_out   <= reg_wen;
            mem_wen_out   <= mem_wen;
            mem_ren_out   <= mem_ren;
            csr_wen_out   <= csr_wen;
            jump_out      <= jump;
            branch_out    <= branch;
            fetch_i_out   <= fetch_i;
            imm_out       <= imm;
            rs2_value_out <= rs2_value;
            csr_value_out <= csr_value;
            rs1_q         <= rs1_value;
            imm_kind_q    <= imm_kind;
            alu_op_q      <= alu_op;
            src1_sel_q    <= src1_sel;
            src2_sel_q    <= src2_sel;
            invert_q      <= invert;
        end
    end

    imm_expand u_imm_expand (
        .imm_raw   (imm_out),
        .kind      (imm_kind_q),
        .imm_value (imm_value)
    );

    always_comb begin
        case (src1_sel_q)
            src1_rs1: operand_a = rs1_q;
            src1_pc:  operand_a = pc_out;
            default:  operand_a = '0;   // lui path and spare code
        endcase
    end

    always_comb begin
        case (src2_sel_q)
            src2_imm: operand_b = imm_value;
            src2_rs2: operand_b = rs2_value_out;
            src2_csr: operand_b = csr_value_out;
            default:  operand_b = '0;
        endcase
    end

    alu u_alu (
        .operand_a (operand_a),
        .operand_b (operand_b),
        .op        (alu_op_q),
        .result    (alu_result)
    );

    // bne/bge/bgeu come from flipping the compare bit
    assign result = alu_result ^ {{(xlen-1){1'b0}}, invert_q};

endmodule

// ==== verilog/exu_top.sv ====
`timescale 1ns/1ps

module exu_top #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      in_valid,
    output logic                      in_ready,
    output logic                      out_valid,
    input  logic                      out_ready,
    input  logic [exu_pkg::xlen-1:0]  pc,
    input  logic [31:0]               inst,
    input  logic [4:0]                rd,
    input  logic [2:0]                funct3,
    input  logic                      reg_wen,
    input  logic                      mem_wen,
    input  logic                      mem_ren,
    input  logic [3:0]                csr_wen,
    input  logic [exu_pkg::xlen-1:0]  imm,
    input  exu_pkg::imm_kind_t        imm_kind,
    input  exu_pkg::alu_op_t          alu_op,
    input  exu_pkg::src1_sel_t        src1_sel,
    input  exu_pkg::src2_sel_t        src2_sel,
    input  logic                      invert,
    input  logic                      jump,
    input  logic                      branch,
    input  logic                      fetch_i,
    input  logic [exu_pkg::xlen-1:0]  rs1_value,
    input  logic [exu_pkg::xlen-1:0]  rs2_value,
    input  logic [exu_pkg::xlen-1:0]  csr_value,
    output logic [exu_pkg::xlen-1:0]  pc_out,
    output logic [31:0]               inst_out,
    output logic [4:0]                rd_out,
    output logic [2:0]                funct3_out,
    output logic                      reg_wen_out,
    output logic                      mem_wen_out,
    output logic                      mem_ren_out,
    output logic [3:0]                csr_wen_out,
    output logic                      jump_out,
    output logic                      branch_out,
    output logic                      fetch_i_out,
    output logic [exu_pkg::xlen-1:0]  imm_out,
    output logic [exu_pkg::xlen-1:0]  rs2_value_out,
    output logic [exu_pkg::xlen-1:0]  csr_value_out,
    output logic [exu_pkg::xlen-1:0]  result,
    output logic [COUNT_WIDTH-1:0]    exec_count
);

    // counter width is fixed here and handed down
    exu #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_exu (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .pc            (pc),
        .inst          (inst),
        .rd            (rd),
        .funct3        (funct3),
        .reg_wen       (reg_wen),
        .mem_wen       (mem_wen),
        .mem_ren       (mem_ren),
        .csr_wen       (csr_wen),
        .imm           (imm),
        .imm_kind      (imm_kind),
        .alu_op        (alu_op),
        .src1_sel      (src1_sel),
        .src2_sel      (src2_sel),
        .invert        (invert),
        .jump          (jump),
        .branch        (branch),
        .fetch_i       (fetch_i),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .csr_value     (csr_value),
        .pc_out        (pc_out),
        .inst_out      (inst_out),
        .rd_out        (rd_out),
        .funct3_out    (funct3_out),
        .reg_wen_out   (reg_wen_out),
        .mem_wen_out   (mem_wen_out),
        .mem_ren_out   (mem_ren_out),
        .csr_wen_out   (csr_wen_out),
        .jump_out      (jump_out),
        .branch_out    (branch_out),
        .fetch_i_out   (fetch_i_out),
        .imm_out       (imm_out),
        .rs2_value_out (rs2_value_out),
        .csr_value_out (csr_value_out),
        .result        (result),
        .exec_count    (exec_count)
    );

endmodule

// ==== sim/exu_assertions.sv ====
`timescale 1ns/1ps

module exu_assertions (
    input logic        clock,
    input logic        reset,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input logic [31:0] result,
    input logic [31:0] pc_out,
    input logic [4:0]  rd_out
);

    // stage must be empty during reset
    assert property (@(posedge clock) reset |-> !out_valid)
        else $error("out_valid high during reset");

    assert property (@(posedge clock) disable iff (reset)
        in_ready == (out_ready || !out_valid))
        else $error("in_ready does not follow out_ready and out_valid");

    // stalled item stays put
    assert property (@(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(result) && $stable(pc_out) && $stable(rd_out)))
        else $error("held output changed under back-pressure");

endmodule

bind exu_top exu_assertions u_exu_assertions (
    .clock     (clock),
    .reset     (reset),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .result    (result),
    .pc_out    (pc_out),
    .rd_out    (rd_out)
);

// ==== sim/tb_exu.sv ====
`timescale 1ns/1ps

module tb_exu;

    import exu_pkg::*;

    typedef struct {
        logic [31:0] pc, inst, imm, rs1, rs2, csr;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [3:0]  csr_wen;
        logic        reg_wen, mem_wen, mem_ren, jump, branch, fetch_i, invert;
        imm_kind_t   imm_kind;
        alu_op_t     alu_op;
        src1_sel_t   src1_sel;
        src2_sel_t   src2_sel;
    } instr_t;

    logic clock, reset, in_valid, in_ready, out_valid, out_ready;
    logic [31:0] pc, inst, imm, rs1_value, rs2_value, csr_value;
    logic [4:0] rd;
    logic [2:0] funct3;
    logic reg_wen, mem_wen, mem_ren, invert, jump, branch, fetch_i;
    logic [3:0] csr_wen;
    imm_kind_t imm_kind;
    alu_op_t alu_op;
    src1_sel_t src1_sel;
    src2_sel_t src2_sel;
    logic [31:0] pc_out, inst_out, imm_out, rs2_value_out, csr_value_out, result;
    logic [4:0] rd_out;
    logic [2:0] funct3_out;
    logic reg_wen_out, mem_wen_out, mem_ren_out, jump_out, branch_out, fetch_i_out;
    logic [3:0] csr_wen_out;
    logic [31:0] exec_count;

    instr_t pending[$];   // accepted but not yet seen at the output
    int in_count, stretch;
    logic stall_mode;

    exu_top #(.COUNT_WIDTH(32)) i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: time %0t signal %s got 0x%08h expected 0x%08h",
                     $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] expected_result(instr_t t);
        logic [31:0] ival, a, b, r;
        case (int'(t.imm_kind))
            0: ival = {{20{t.imm[11]}}, t.imm[11:0]};
            1: ival = {t.imm[19:0], 12'h000};
            2: ival = {{11{t.imm[19]}}, t.imm[19:0], 1'b0};
            default: ival = {27'd0, t.imm[4:0]};
        endcase
        case (int'(t.src1_sel))
            0: a = t.rs1;
            1: a = t.pc;
            default: a = 32'd0;
        endcase
        case (int'(t.src2_sel))
            0: b = ival;
            1: b = t.rs2;
            2: b = t.csr;
            default: b = 32'd0;
        endcase
        case (int'(t.alu_op))
            0: r = a + b;
            1: r = a - b;
            2: r = a << b[4:0];
            3: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: r = (a < b) ? 32'd1 : 32'd0;
            5: r = a ^ b;
            6: r = a >> b[4:0];
            7: r = $signed(a) >>> b[4:0];
            8: r = a | b;
            9: r = a & b;
            10: r = (a == b) ? 32'd1 : 32'd0;
            default: r = 32'd0;
        endcase
        return r ^ {31'd0, t.invert};
    endfunction

    // drives one instruction and waits for the input handshake
    task automatic send(int op, int s1, int s2, int kind, logic inv,
                        logic [31:0] a, logic [31:0] b, logic [31:0] c, logic [31:0] iv);
        int waited;
        @(negedge clock);
        in_valid = 1'b1;
        alu_op = alu_op_t'(op);
        src1_sel = src1_sel_t'(s1);
        src2_sel = src2_sel_t'(s2);
        imm_kind = imm_kind_t'(kind);
        invert = inv;
        rs1_value = a;
        rs2_value = b;
        csr_value = c;
        imm = iv;
        pc = {$urandom} & 32'hffff_fffc;
        inst = $urandom;
        rd = 5'($urandom);
        funct3 = 3'($urandom);
        {reg_wen, mem_wen, mem_ren, jump, branch, fetch_i} = 6'($urandom);
        csr_wen = 4'($urandom);
        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > 100) begin
                $display("timeout: decode side handshake never completed");
                $display("sim failed");
                $fatal(1, "input timeout");
            end
        end while (!in_ready);
    endtask

    // input side monitor
    always @(posedge clock) begin
        instr_t t;
        if (!reset && in_valid && in_ready) begin
            t.pc = pc;
            t.inst = inst;
            t.imm = imm;
            t.rs1 = rs1_value;
            t.rs2 = rs2_value;
            t.csr = csr_value;
            t.rd = rd;
            t.funct3 = funct3;
            t.csr_wen = csr_wen;
            t.reg_wen = reg_wen;
            t.mem_wen = mem_wen;
            t.mem_ren = mem_ren;
            t.jump = jump;
            t.branch = branch;
            t.fetch_i = fetch_i;
            t.invert = invert;
            t.imm_kind = imm_kind;
            t.alu_op = alu_op;
            t.src1_sel = src1_sel;
            t.src2_sel = src2_sel;
            pending.push_back(t);
            in_count++;
        end
    end

    // comparing process on the output side
    always @(posedge clock) begin
        instr_t t;
        if (!reset && out_valid && !out_ready)
            check_value("in_ready", {31'd0, in_ready}, 32'd0);
        if (!reset && out_valid && out_ready) begin
            if (pending.size() == 0) begin
                $display("output transfer with no instruction outstanding");
                $display("sim failed");
                $fatal(1, "extra output");
            end
            t = pending.pop_front();
            check_value("result", result, expected_result(t));
            check_value("pc_out", pc_out, t.pc);
            check_value("inst_out", inst_out, t.inst);
            check_value("rd_out", {27'd0, rd_out}, {27'd0, t.rd});
            check_value("funct3_out", {29'd0, funct3_out}, {29'd0, t.funct3});
            check_value("reg_wen_out", {31'd0, reg_wen_out}, {31'd0, t.reg_wen});
            check_value("mem_wen_out", {31'd0, mem_wen_out}, {31'd0, t.mem_wen});
            check_value("mem_ren_out", {31'd0, mem_ren_out}, {31'd0, t.mem_ren});
            check_value("csr_wen_out", {28'd0, csr_wen_out}, {28'd0, t.csr_wen});
            check_value("jump_out", {31'd0, jump_out}, {31'd0, t.jump});
            check_value("branch_out", {31'd0, branch_out}, {31'd0, t.branch});
            check_value("fetch_i_out", {31'd0, fetch_i_out}, {31'd0, t.fetch_i});
            check_value("imm_out", imm_out, t.imm);
            check_value("rs2_value_out", rs2_value_out, t.rs2);
            check_value("csr_value_out", csr_value_out, t.csr);
        end
    end

    // memory side back-pressure in random stretches
    always @(negedge clock) begin
        if (!stall_mode) begin
            out_ready = 1'b1;
        end else if (stretch == 0) begin
            out_ready = ~out_ready;
            stretch = 1 + ($urandom % 6);
        end else begin
            stretch--;
        end
    end

    initial begin
        int waited;
        logic [31:0] x;
        void'($urandom(41081));
        reset = 1'b1;
        in_valid = 1'b0;
        out_ready = 1'b1;
        stall_mode = 1'b0;
        {pc, inst, imm, rs1_value, rs2_value, csr_value} = '0;
        {rd, funct3, csr_wen} = '0;
        {reg_wen, mem_wen, mem_ren, invert, jump, branch, fetch_i} = '0;
        imm_kind = imm_12i;
        alu_op = alu_add;
        src1_sel = src1_rs1;
        src2_sel = src2_imm;
        in_count = 0;
        stretch = 0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_value("out_valid", {31'd0, out_valid}, 32'd0);
        check_value("exec_count", exec_count, 32'd0);

        for (int i = 0; i < 66; i++)   // register-register over every code
            send(i % 11, 0, 1, 0, 1'b0, $urandom, $urandom, $urandom, $urandom);
        for (int k = 0; k < 4; k++)
            send(0, 0, 0, k, 1'b0, $urandom, $urandom, $urandom, $urandom);
        send(0, 1, 0, 1, 1'b0, $urandom, $urandom, $urandom, $urandom);  // auipc
        send(0, 1, 0, 2, 1'b0, $urandom, $urandom, $urandom, $urandom);  // jal target
        send(8, 0, 2, 0, 1'b0, $urandom, $urandom, $urandom, $urandom);  // csrrs style
        send(0, 2, 0, 1, 1'b0, $urandom, $urandom, $urandom, $urandom);  // lui
        send(0, 2, 2, 3, 1'b0, $urandom, $urandom, $urandom, $urandom);
        for (int i = 0; i < 24; i++) begin
            x = $urandom;
            // equal operands every few rounds so eq/ne both show up
            send(3 + (i % 3 == 0 ? 7 : i % 3 - 1), 0, 1, 0, i[0],
                 x, (i % 4 == 0) ? x : $urandom, $urandom, $urandom);
        end

        stall_mode = 1'b1;
        for (int i = 0; i < 80; i++)
            send($urandom % 12, $urandom % 4, $urandom % 4, $urandom % 4, 1'($urandom),
                 $urandom, $urandom, $urandom, $urandom);
        @(negedge clock);
        in_valid = 1'b0;
        stall_mode = 1'b0;

        waited = 0;
        while (pending.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > 200) begin
                $display("timeout: outstanding instructions never left the stage");
                $display("sim failed");
                $fatal(1, "drain timeout");
            end
        end
        check_value("exec_count", exec_count, in_count);

        $display("sim passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/exu_pkg.sv
verilog/alu.sv
verilog/imm_expand.sv
verilog/exu.sv
verilog/exu_top.sv
sim/exu_assertions.sv
sim/tb_exu.sv

// ==== run_sim.sh ====
#!/bin/bash
# builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module tb_exu \
    -o tb_exu_sim
if [ $? -ne 0 ]; then
    echo "build step failed"
    exit 1
fi

./obj_dir/tb_exu_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator returned status $run_status"
    exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
    echo "run ended without a result line"
    exit 1
fi
exit 0
